/* mmio_subsystem.f */
src/mmio_map_pkg.sv
src/periph_pkg.sv
src/byte_access_sequencer.sv
src/gpio_port.sv
src/timer_unit.sv
src/memory_controller.sv
src/mmio_subsystem.sv
test/mmio_subsystem_asserts.sv
test/mmio_subsystem_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with verilator.

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -f mmio_subsystem.f \
    --top-module mmio_subsystem_tb -Mdir obj_dir -o mmio_subsystem_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/mmio_subsystem_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* src/byte_access_sequencer.sv */
`timescale 1ns/1ps

module byte_access_sequencer (
    input  logic        hwclk,
    input  logic        nrst,
    input  logic        ext_req,
    input  logic        ext_write,
    input  logic        ext_dbl,
    input  logic [15:0] ext_addr,
    input  logic [15:0] ext_wdata,
    input  logic [7:0]  mem_rdata,
    output logic        ext_ack,
    output logic [15:0] ext_rdata,
    output logic [15:0] mem_addr,
    output logic [7:0]  mem_wdata,
    output logic        mem_wr
);

    // byte 0 goes out in idle, byte 1 in s_high.
    localparam logic [2:0] S_IDLE = 3'd0;
    localparam logic [2:0] S_HIGH = 3'd1;
    localparam logic [2:0] S_TAIL = 3'd2;
    localparam logic [2:0] S_ACK = 3'd3;
    localparam logic [2:0] S_REST = 3'd4;

    logic [2:0]  state_q;
    logic [2:0]  state_d;
    logic [15:0] rdata_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: if (ext_req) state_d = ext_dbl ? S_HIGH : S_TAIL;
            S_HIGH: state_d = S_TAIL;
            S_TAIL: state_d = S_ACK;
            S_ACK: state_d = S_REST;
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge hwclk, negedge nrst) begin
        if (!nrst) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // memory side.
    always_comb begin
        mem_addr = ext_addr;
        mem_wdata = ext_wdata[7:0];
        mem_wr = 1'b0;
        case (state_q)
            S_IDLE: mem_wr = ext_req & ext_write;
            S_HIGH: begin
                mem_addr = ext_addr + 16'd1;
                mem_wdata = ext_wdata[15:8];
                mem_wr = ext_write;
            end
            default: ;
        endcase
    end

    // read bytes arrive one cycle behind their address.
    always_ff @(posedge hwclk) begin
        if (state_q == S_IDLE || state_q == S_ACK) begin
            rdata_q <= '0;
        end else if (state_q == S_HIGH) begin
            rdata_q[7:0] <= mem_rdata;
        end else if (state_q == S_TAIL) begin
            if (ext_dbl) rdata_q[15:8] <= mem_rdata;
            else rdata_q[7:0] <= mem_rdata;
        end
    end

    assign ext_ack = (state_q == S_ACK);
    assign ext_rdata = rdata_q;

endmodule

/* src/gpio_port.sv */
`timescale 1ns/1ps

module gpio_port #(
    parameter int GPIO_WIDTH = 8
) (
    input  logic        hwclk,
    input  logic        nrst,
    input  logic        gpio_dir_we,
    input  logic        gpio_out_we,
    input  logic [2:0]  reg_idx,
    input  logic [15:0] wdata,
    input  logic [7:0]  irq_mask,
    input  logic [7:0]  gpio_in,
    output logic [15:0] gpio_rdata,
    output logic [7:0]  gpio_dir,
    output logic [7:0]  gpio_out,
    output logic        gpio_irq
);

    // pins above GPIO_WIDTH stay inputs and read zero.
    localparam logic [7:0] PIN_MASK = 8'((9'd1 << GPIO_WIDTH) - 9'd1);

    logic [7:0] dir_q;
    logic [7:0] out_q;
    logic [7:0] pins;
    logic       pin_bit;

    assign pins = gpio_in & PIN_MASK;

    // dir bit 1 means output.
    always_ff @(posedge hwclk, negedge nrst) begin
        if (!nrst) begin
            dir_q <= 8'b0;
            out_q <= 8'b0;
        end else begin
            if (gpio_dir_we && PIN_MASK[reg_idx]) dir_q[reg_idx] <= wdata[0];
            if (gpio_out_we && dir_q[reg_idx]) out_q[reg_idx] <= wdata[0];
        end
    end

    assign pin_bit = dir_q[reg_idx] ? out_q[reg_idx] : pins[reg_idx];

    // bit 8 is the pin view, low byte the direction view.
    assign gpio_rdata = {7'b0, pin_bit, dir_q};

    assign gpio_dir = dir_q;
    assign gpio_out = out_q;

    // mask bit 1 enables the pin.
    assign gpio_irq = |(pins & ~dir_q & irq_mask);

endmodule

/* src/memory_controller.sv */
`timescale 1ns/1ps

module memory_controller import mmio_map_pkg::*; #(
    parameter logic [15:0] MMIO_START_ADDR = mmio_start_default,
    parameter logic [7:0]  GPIO_CTRL_OFFSET = gpio_ctrl_off,
    parameter logic [7:0]  GPIO_PIN_OFFSET = gpio_pin_off,
    parameter logic [7:0]  SS_OFFSET = ss_off,
    parameter logic [7:0]  IH_OFFSET = ih_off,
    parameter logic [7:0]  IRQ_MASK_OFFSET = irq_mask_off,
    parameter logic [7:0]  TIMER_OFFSET = timer_off
) (
    input  logic        hwclk,
    input  logic        nrst,
    input  logic        mem_read_en,
    input  logic        mem_write_en,
    input  logic        dbl_byte_en,
    input  logic [15:0] address,
    input  logic [15:0] data_in,
    input  logic [15:0] input_handler,
    input  logic [15:0] gpio_rdata,
    input  logic [15:0] timer_rdata,
    input  logic        ext_ack,
    input  logic [15:0] ext_rdata,
    output logic        ack,
    output logic [15:0] data_output,
    output logic [7:0]  ss0, ss1, ss2, ss3, ss4, ss5, ss6, ss7,
    output logic        input_handler_enable,
    output logic [7:0]  irq_mask,
    output logic        gpio_dir_we,
    output logic        gpio_out_we,
    output logic        timer_we,
    output logic        wdbl,
    output logic [2:0]  reg_idx,
    output logic [15:0] wdata,
    output logic        ext_req,
    output logic        ext_write,
    output logic        ext_dbl,
    output logic [15:0] ext_addr,
    output logic [15:0] ext_wdata
);

    // **************************************************
    // address decode.
    // **************************************************
    localparam logic [15:0] GPIO_CTRL_LO = MMIO_START_ADDR + {8'b0, GPIO_CTRL_OFFSET};
    localparam logic [15:0] GPIO_CTRL_HI = GPIO_CTRL_LO + gpio_ctrl_size - 16'd1;
    localparam logic [15:0] GPIO_PIN_LO = MMIO_START_ADDR + {8'b0, GPIO_PIN_OFFSET};
    localparam logic [15:0] GPIO_PIN_HI = GPIO_PIN_LO + gpio_pin_size - 16'd1;
    localparam logic [15:0] SS_LO = MMIO_START_ADDR + {8'b0, SS_OFFSET};
    localparam logic [15:0] SS_HI = SS_LO + ss_size - 16'd1;
    localparam logic [15:0] IH_LO = MMIO_START_ADDR + {8'b0, IH_OFFSET};
    localparam logic [15:0] IH_HI = IH_LO + ih_size - 16'd1;
    localparam logic [15:0] IRQ_MASK_LO = MMIO_START_ADDR + {8'b0, IRQ_MASK_OFFSET};
    localparam logic [15:0] IRQ_MASK_HI = IRQ_MASK_LO + irq_mask_size - 16'd1;
    localparam logic [15:0] TIMER_LO = MMIO_START_ADDR + {8'b0, TIMER_OFFSET};
    localparam logic [15:0] TIMER_HI = TIMER_LO + timer_size - 16'd1;

    logic hit_gpio_ctrl, hit_gpio_pin, hit_ss, hit_ih, hit_irq_mask, hit_timer, hit_ext;
    logic       access;
    logic [2:0] idx;
    logic [7:0] ss_q [8];
    logic       ih_en_q;
    logic [7:0] irq_mask_q;

    assign hit_gpio_ctrl = (address >= GPIO_CTRL_LO) && (address <= GPIO_CTRL_HI);
    assign hit_gpio_pin = (address >= GPIO_PIN_LO) && (address <= GPIO_PIN_HI);
    assign hit_ss = (address >= SS_LO) && (address <= SS_HI);
    assign hit_ih = (address >= IH_LO) && (address <= IH_HI);
    assign hit_irq_mask = (address >= IRQ_MASK_LO) && (address <= IRQ_MASK_HI);
    assign hit_timer = (address >= TIMER_LO) && (address <= TIMER_HI);
    assign hit_ext = ~(hit_gpio_ctrl | hit_gpio_pin | hit_ss | hit_ih | hit_irq_mask | hit_timer);

    assign access = mem_read_en | mem_write_en;
    // regions sit on 16-byte offsets, so low bits are the index.
    assign idx = address[2:0];

    // strobes to gpio and timer.
    assign gpio_dir_we = hit_gpio_ctrl & mem_write_en;
    assign gpio_out_we = hit_gpio_pin & mem_write_en;
    assign timer_we = hit_timer & mem_write_en;
    assign wdbl = dbl_byte_en;
    assign reg_idx = idx;
    assign wdata = data_in;

    // external path.
    assign ext_req = hit_ext & access;
    assign ext_write = mem_write_en;
    assign ext_dbl = dbl_byte_en;
    assign ext_addr = address;
    assign ext_wdata = data_in;

    assign ack = hit_ext ? ext_ack : access;

    // **************************************************
    // local registers.
    // **************************************************
    always_ff @(posedge hwclk, negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < 8; i++) begin
                ss_q[i] <= 8'b0;
            end
            ih_en_q <= 1'b0;
            irq_mask_q <= 8'b0;
        end else if (mem_write_en) begin
            if (hit_ss) ss_q[idx] <= data_in[7:0];
            if (hit_ih && idx == 3'd2) ih_en_q <= data_in[0];
            if (hit_irq_mask) irq_mask_q <= data_in[7:0];
        end
    end

    // read mux.
    always_comb begin
        data_output = 16'b0;
        if (mem_read_en) begin
            if (hit_ih) begin
                if (dbl_byte_en && idx != 3'd2) data_output = input_handler;
                else if (idx == 3'd0) data_output = {8'b0, input_handler[7:0]};
                else if (idx == 3'd1) data_output = {8'b0, input_handler[15:8]};
                else data_output = {15'b0, ih_en_q};
            end else if (hit_gpio_ctrl) begin
                data_output = {8'b0, gpio_rdata[7:0]};
            end else if (hit_gpio_pin) begin
                data_output = {15'b0, gpio_rdata[8]};
            end else if (hit_ss) begin
                data_output = {8'b0, ss_q[idx]};
            end else if (hit_irq_mask) begin
                data_output = {8'b0, irq_mask_q};
            end else if (hit_timer) begin
                data_output = timer_rdata;
            end else begin
                data_output = ext_rdata;
            end
        end
    end

    assign ss0 = ss_q[0];
    assign ss1 = ss_q[1];
    assign ss2 = ss_q[2];
    assign ss3 = ss_q[3];
    assign ss4 = ss_q[4];
    assign ss5 = ss_q[5];
    assign ss6 = ss_q[6];
    assign ss7 = ss_q[7];
    assign input_handler_enable = ih_en_q;
    assign irq_mask = irq_mask_q;

endmodule

/* src/mmio_map_pkg.sv */
package mmio_map_pkg;

    // **************************************************
    // peripheral window base.
    // **************************************************
    localparam logic [15:0] mmio_start_default = 16'hff00;

    // region offsets inside the window.
    localparam logic [7:0] gpio_ctrl_off = 8'h80;
    localparam logic [7:0] gpio_pin_off = 8'h90;
    localparam logic [7:0] ss_off = 8'ha0;
    localparam logic [7:0] ih_off = 8'hb0;
    localparam logic [7:0] irq_mask_off = 8'hc0;
    localparam logic [7:0] timer_off = 8'hd0;

    // **************************************************
    // region sizes in bytes.
    // **************************************************
    localparam logic [15:0] gpio_ctrl_size = 16'd8;
    localparam logic [15:0] gpio_pin_size = 16'd8;
    localparam logic [15:0] ss_size = 16'd8;
    // ih low, ih high, enable.
    localparam logic [15:0] ih_size = 16'd3;
    localparam logic [15:0] irq_mask_size = 16'd1;
    // enable, then four duration lanes.
    localparam logic [15:0] timer_size = 16'd5;

endpackage

/* src/mmio_subsystem.sv */
`timescale 1ns/1ps

module mmio_subsystem import mmio_map_pkg::*; #(
    parameter logic [15:0] MMIO_START_ADDR = mmio_start_default,
    parameter logic [7:0]  GPIO_CTRL_OFFSET = gpio_ctrl_off,
    parameter logic [7:0]  GPIO_PIN_OFFSET = gpio_pin_off,
    parameter logic [7:0]  SS_OFFSET = ss_off,
    parameter logic [7:0]  IH_OFFSET = ih_off,
    parameter logic [7:0]  IRQ_MASK_OFFSET = irq_mask_off,
    parameter logic [7:0]  TIMER_OFFSET = timer_off,
    parameter int          GPIO_WIDTH = 8
) (
    input  logic        hwclk,
    input  logic        nrst,
    input  logic        mem_read_en,
    input  logic        mem_write_en,
    input  logic        dbl_byte_en,
    input  logic [15:0] address,
    input  logic [15:0] data_in,
    output logic        ack,
    output logic [15:0] data_output,
    output logic [15:0] mem_addr,
    output logic [7:0]  mem_wdata,
    input  logic [7:0]  mem_rdata,
    output logic        mem_wr,
    input  logic [15:0] input_handler,
    input  logic [7:0]  gpio_in,
    output logic [7:0]  gpio_dir,
    output logic [7:0]  gpio_out,
    output logic        gpio_irq,
    output logic [7:0]  ss0, ss1, ss2, ss3, ss4, ss5, ss6, ss7,
    output logic        input_handler_enable,
    output logic [7:0]  irq_mask,
    output logic        timer_enable,
    output logic        timer_tick
);

    logic        gpio_dir_we, gpio_out_we, timer_we, wdbl;
    logic [2:0]  reg_idx;
    logic [15:0] wdata, gpio_rdata, timer_rdata;
    logic        ext_req, ext_write, ext_dbl, ext_ack;
    logic [15:0] ext_addr, ext_wdata, ext_rdata;

    memory_controller #(
        .MMIO_START_ADDR(MMIO_START_ADDR),
        .GPIO_CTRL_OFFSET(GPIO_CTRL_OFFSET),
        .GPIO_PIN_OFFSET(GPIO_PIN_OFFSET),
        .SS_OFFSET(SS_OFFSET),
        .IH_OFFSET(IH_OFFSET),
        .IRQ_MASK_OFFSET(IRQ_MASK_OFFSET),
        .TIMER_OFFSET(TIMER_OFFSET)
    ) u_memory_controller (
        .hwclk(hwclk), .nrst(nrst),
        .mem_read_en(mem_read_en), .mem_write_en(mem_write_en), .dbl_byte_en(dbl_byte_en),
        .address(address), .data_in(data_in), .input_handler(input_handler),
        .gpio_rdata(gpio_rdata), .timer_rdata(timer_rdata),
        .ext_ack(ext_ack), .ext_rdata(ext_rdata),
        .ack(ack), .data_output(data_output),
        .ss0(ss0), .ss1(ss1), .ss2(ss2), .ss3(ss3),
        .ss4(ss4), .ss5(ss5), .ss6(ss6), .ss7(ss7),
        .input_handler_enable(input_handler_enable), .irq_mask(irq_mask),
        .gpio_dir_we(gpio_dir_we), .gpio_out_we(gpio_out_we),
        .timer_we(timer_we), .wdbl(wdbl), .reg_idx(reg_idx), .wdata(wdata),
        .ext_req(ext_req), .ext_write(ext_write), .ext_dbl(ext_dbl),
        .ext_addr(ext_addr), .ext_wdata(ext_wdata)
    );

    byte_access_sequencer u_byte_access_sequencer (
        .hwclk(hwclk), .nrst(nrst),
        .ext_req(ext_req), .ext_write(ext_write), .ext_dbl(ext_dbl),
        .ext_addr(ext_addr), .ext_wdata(ext_wdata), .mem_rdata(mem_rdata),
        .ext_ack(ext_ack), .ext_rdata(ext_rdata),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_wr(mem_wr)
    );

    gpio_port #(
        .GPIO_WIDTH(GPIO_WIDTH)
    ) u_gpio_port (
        .hwclk(hwclk), .nrst(nrst),
        .gpio_dir_we(gpio_dir_we), .gpio_out_we(gpio_out_we),
        .reg_idx(reg_idx), .wdata(wdata), .irq_mask(irq_mask), .gpio_in(gpio_in),
        .gpio_rdata(gpio_rdata), .gpio_dir(gpio_dir), .gpio_out(gpio_out),
        .gpio_irq(gpio_irq)
    );

    timer_unit u_timer_unit (
        .hwclk(hwclk), .nrst(nrst),
        .timer_we(timer_we), .wdbl(wdbl), .reg_idx(reg_idx), .wdata(wdata),
        .timer_rdata(timer_rdata), .timer_enable(timer_enable), .timer_tick(timer_tick)
    );

endmodule

/* src/periph_pkg.sv */
package periph_pkg;

    // **************************************************
    // timer duration.
    // **************************************************

    // one count, or four byte lanes from the low end.
    typedef union packed {
        logic [31:0] count;
        logic [3:0][7:0] lane;
    } timer_dur_u;

    // 200 Hz tick at 10 MHz.
    localparam logic [31:0] timer_dur_reset = 32'd50000;

endpackage

/* src/timer_unit.sv */
`timescale 1ns/1ps

module timer_unit import periph_pkg::*; (
    input  logic        hwclk,
    input  logic        nrst,
    input  logic        timer_we,
    input  logic        wdbl,
    input  logic [2:0]  reg_idx,
    input  logic [15:0] wdata,
    output logic [15:0] timer_rdata,
    output logic        timer_enable,
    output logic        timer_tick
);

    logic        enable_q;
    timer_dur_u  dur_q;
    logic [31:0] count_q;
    logic        tick_q;
    logic [1:0]  lane_idx;
    logic        hi_half;

    assign lane_idx = reg_idx[1:0] - 2'd1;
    assign hi_half = (reg_idx >= 3'd3);

    // **************************************************
    // register writes.
    // **************************************************
    always_ff @(posedge hwclk, negedge nrst) begin
        if (!nrst) begin
            enable_q <= 1'b0;
            dur_q.count <= timer_dur_reset;
        end else if (timer_we) begin
            if (reg_idx == 3'd0) begin
                enable_q <= wdata[0];
            end else if (reg_idx <= 3'd4) begin
                if (wdbl && hi_half) begin
                    dur_q.lane[3] <= wdata[15:8];
                    dur_q.lane[2] <= wdata[7:0];
                end else if (wdbl) begin
                    dur_q.lane[1] <= wdata[15:8];
                    dur_q.lane[0] <= wdata[7:0];
                end else begin
                    dur_q.lane[lane_idx] <= wdata[7:0];
                end
            end
        end
    end

    always_comb begin
        timer_rdata = 16'b0;
        if (reg_idx == 3'd0) timer_rdata = {15'b0, enable_q};
        else if (reg_idx <= 3'd4 && wdbl) timer_rdata = hi_half ? dur_q.count[31:16] :
                                                                 dur_q.count[15:0];
        else if (reg_idx <= 3'd4) timer_rdata = {8'b0, dur_q.lane[lane_idx]};
    end

    // **************************************************
    // countdown, tick on reload.
    // **************************************************
    always_ff @(posedge hwclk, negedge nrst) begin
        if (!nrst) begin
            count_q <= timer_dur_reset;
            tick_q <= 1'b0;
        end else if (!enable_q) begin
            count_q <= dur_q.count;
            tick_q <= 1'b0;
        end else if (count_q == 32'd0) begin
            count_q <= dur_q.count;
            tick_q <= 1'b1;
        end else begin
            count_q <= count_q - 32'd1;
            tick_q <= 1'b0;
        end
    end

    assign timer_enable = enable_q;
    assign timer_tick = tick_q;

endmodule

/* test/mmio_subsystem_asserts.sv */
`timescale 1ns/1ps

module mmio_subsystem_asserts (
    input logic hwclk,
    input logic nrst,
    input logic mem_read_en,
    input logic mem_write_en,
    input logic ack,
    input logic ext_ack,
    input logic mem_wr
);

    int fail_count = 0;

    // ack only answers a live request.
    ack_needs_enable: assert property (
        @(posedge hwclk) disable iff (!nrst) ack |-> (mem_read_en || mem_write_en)
    ) else begin
        fail_count++;
        $error("ack seen without a read or write enable");
    end

    ext_ack_one_cycle: assert property (
        @(posedge hwclk) disable iff (!nrst) ext_ack |=> !ext_ack
    ) else begin
        fail_count++;
        $error("ext_ack stayed high for more than one cycle");
    end

    // handshake outputs quiet right after reset.
    quiet_after_reset: assert property (
        @(posedge hwclk) $rose(nrst) |=> (!ack && !ext_ack && !mem_wr)
    ) else begin
        fail_count++;
        $error("ack, ext_ack or mem_wr high one cycle after reset release");
    end

endmodule

bind mmio_subsystem mmio_subsystem_asserts u_mmio_subsystem_asserts (
    .hwclk(hwclk),
    .nrst(nrst),
    .mem_read_en(mem_read_en),
    .mem_write_en(mem_write_en),
    .ack(ack),
    .ext_ack(ext_ack),
    .mem_wr(mem_wr)
);

/* test/mmio_subsystem_tb.sv */
`timescale 1ns/1ps

module mmio_subsystem_tb import periph_pkg::*; ();

    localparam int PERIOD = 20;
    localparam int ACCESS_COUNT = 84;
    localparam int TICK_PERIODS = 4;
    localparam int TIMER_CYCLES = 6 * (TICK_PERIODS + 2);
    localparam logic [15:0] GPIO_CTRL = 16'hff80;
    localparam logic [15:0] GPIO_PIN = 16'hff90;
    localparam logic [15:0] SS_BASE = 16'hffa0;
    localparam logic [15:0] IH_BASE = 16'hffb0;
    localparam logic [15:0] IRQ_MASK = 16'hffc0;
    localparam logic [15:0] TIMER = 16'hffd0;

    logic        hwclk = 1'b0;
    logic        nrst = 1'b0;
    logic        mem_read_en = 1'b0;
    logic        mem_write_en = 1'b0;
    logic        dbl_byte_en = 1'b0;
    logic [15:0] address = 16'h0000;
    logic [15:0] data_in = 16'h0000;
    logic [15:0] input_handler = 16'h0000;
    logic [7:0]  gpio_in = 8'h00;
    logic [7:0]  mem_rdata = 8'h00;
    logic        ack, mem_wr, gpio_irq, input_handler_enable, timer_enable, timer_tick;
    logic [15:0] data_output, mem_addr;
    logic [7:0]  mem_wdata, gpio_dir, gpio_out, irq_mask;
    logic [7:0]  ss0, ss1, ss2, ss3, ss4, ss5, ss6, ss7;
    logic [7:0]  ext_mem [256];
    logic [15:0] last_rdata;
    int          last_lat;
    int          errors = 0;
    int          cycle_count = 0;

    mmio_subsystem u_mmio_subsystem (.*);

    always #(PERIOD / 2) hwclk = ~hwclk;

    always @(posedge hwclk) cycle_count <= cycle_count + 1;

    // byte memory, one cycle read latency.
    always @(posedge hwclk) begin
        if (!nrst) begin
            for (int i = 0; i < 256; i++) begin
                ext_mem[i] <= 8'(i * 37 + 11);
            end
        end else begin
            if (mem_wr) ext_mem[mem_addr[7:0]] <= mem_wdata;
            mem_rdata <= ext_mem[mem_addr[7:0]];
        end
    end

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        assert (actual === expected)
        else begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // **************************************************
    // requester handshake.
    // **************************************************
    task automatic access(input logic wr, input logic dbl, input logic [15:0] addr,
                          input logic [15:0] wd);
        last_lat = 0;
        mem_read_en = !wr;
        mem_write_en = wr;
        dbl_byte_en = dbl;
        address = addr;
        data_in = wd;
        @(negedge hwclk);
        while (!ack && last_lat < 20) begin
            last_lat++;
            @(negedge hwclk);
        end
        if (!ack) begin
            errors++;
            $display("no ack for the access at address %h", addr);
        end
        last_rdata = data_output;
        @(posedge hwclk);
        #2;
        mem_read_en = 1'b0;
        mem_write_en = 1'b0;
        @(posedge hwclk);
        #2;
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [15:0] wd, input logic dbl);
        access(1'b1, dbl, addr, wd);
    endtask

    task automatic read_check(input string name, input logic [15:0] addr, input logic dbl,
                              input logic [15:0] expected);
        access(1'b0, dbl, addr, 16'h0000);
        compare(name, 32'(expected), 32'(last_rdata));
    endtask

    task automatic wait_tick(output int at_cycle);
        int waited;
        waited = 0;
        do begin
            @(negedge hwclk);
            waited++;
        end while (!timer_tick && waited < 20);
        if (!timer_tick) begin
            errors++;
            $display("timer_tick did not pulse within 20 cycles");
        end
        at_cycle = cycle_count;
    endtask

    initial begin
        #(PERIOD * (6 + 40 * ACCESS_COUNT + TIMER_CYCLES));
        $display("watchdog expired before the tests finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        timer_dur_u  exp_dur;
        logic [7:0]  ss_exp [8];
        logic [7:0]  dir_pat;
        logic [7:0]  mask;
        logic [15:0] word;
        logic [15:0] ea;
        logic        dbl;
        int          t_last;
        int          t_now;
        int          afails;
        void'($urandom(32'h8e36ae68));
        repeat (4) @(posedge hwclk);
        #2;
        nrst = 1'b1;
        repeat (2) @(posedge hwclk);
        #2;

        // reset values.
        compare("reset ss", 0, 32'({ss0, ss1, ss2, ss3} | {ss4, ss5, ss6, ss7}));
        compare("reset gpio", 0, 32'({gpio_dir, gpio_out, irq_mask}));
        compare("reset flags", 0,
                32'({ack, mem_wr, timer_tick, gpio_irq, input_handler_enable, timer_enable}));
        read_check("reset duration low", TIMER + 16'd1, 1'b1, timer_dur_reset[15:0]);
        read_check("reset duration high", TIMER + 16'd3, 1'b1, timer_dur_reset[31:16]);

        // **************************************************
        // local registers.
        // **************************************************
        for (int i = 0; i < 8; i++) begin
            ss_exp[i] = 8'($urandom);
            write_reg(SS_BASE + 16'(i), {8'h00, ss_exp[i]}, 1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            read_check($sformatf("ss%0d", i), SS_BASE + 16'(i), 1'b0, {8'h00, ss_exp[i]});
        end
        compare("ss0 to ss3 ports", {ss_exp[0], ss_exp[1], ss_exp[2], ss_exp[3]},
                {ss0, ss1, ss2, ss3});
        compare("ss4 to ss7 ports", {ss_exp[4], ss_exp[5], ss_exp[6], ss_exp[7]},
                {ss4, ss5, ss6, ss7});
        mask = 8'($urandom);
        write_reg(IRQ_MASK, {8'h00, mask}, 1'b0);
        read_check("irq mask", IRQ_MASK, 1'b0, {8'h00, mask});
        compare("irq mask port", 32'(mask), 32'(irq_mask));
        write_reg(IH_BASE + 16'd2, 16'h0001, 1'b0);
        read_check("ih enable", IH_BASE + 16'd2, 1'b0, 16'h0001);
        compare("ih enable port", 1, 32'(input_handler_enable));
        input_handler = 16'($urandom);
        read_check("ih word", IH_BASE, 1'b1, input_handler);
        read_check("ih high byte", IH_BASE + 16'd1, 1'b0, {8'h00, input_handler[15:8]});

        // gpio, then output writes to every pin.
        dir_pat = 8'($urandom);
        for (int i = 0; i < 8; i++) begin
            write_reg(GPIO_CTRL + 16'(i), {15'b0, dir_pat[i]}, 1'b0);
        end
        read_check("gpio dir", GPIO_CTRL, 1'b0, {8'h00, dir_pat});
        compare("gpio dir port", 32'(dir_pat), 32'(gpio_dir));
        for (int i = 0; i < 8; i++) begin
            write_reg(GPIO_PIN + 16'(i), 16'h0001, 1'b0);
        end
        compare("gpio out", 32'(dir_pat), 32'(gpio_out));
        gpio_in = 8'($urandom);
        for (int i = 0; i < 8; i++) begin
            read_check($sformatf("gpio pin%0d", i), GPIO_PIN + 16'(i), 1'b0,
                       {15'b0, dir_pat[i] ? 1'b1 : gpio_in[i]});
        end
        for (int k = 0; k < 4; k++) begin
            gpio_in = 8'($urandom);
            mask = 8'($urandom);
            write_reg(IRQ_MASK, {8'h00, mask}, 1'b0);
            compare($sformatf("gpio irq %0d", k), 32'(|(gpio_in & ~dir_pat & mask)),
                    32'(gpio_irq));
        end

        // **************************************************
        // timer lanes and tick.
        // **************************************************
        exp_dur.count = timer_dur_reset;
        for (int i = 0; i < 4; i++) begin
            exp_dur.lane[i] = 8'($urandom);
            write_reg(TIMER + 16'(i + 1), {8'h00, exp_dur.lane[i]}, 1'b0);
        end
        for (int i = 0; i < 4; i++) begin
            read_check($sformatf("timer lane%0d", i), TIMER + 16'(i + 1), 1'b0,
                       {8'h00, exp_dur.lane[i]});
        end
        word = 16'($urandom);
        exp_dur.count[15:0] = word;
        write_reg(TIMER + 16'd1, word, 1'b1);
        word = 16'($urandom);
        exp_dur.count[31:16] = word;
        write_reg(TIMER + 16'd3, word, 1'b1);
        read_check("timer low half", TIMER + 16'd2, 1'b1, exp_dur.count[15:0]);
        read_check("timer high half", TIMER + 16'd4, 1'b1, exp_dur.count[31:16]);
        read_check("timer lane3 after half write", TIMER + 16'd4, 1'b0,
                   {8'h00, exp_dur.lane[3]});
        write_reg(TIMER + 16'd1, 16'd5, 1'b1);
        write_reg(TIMER + 16'd3, 16'd0, 1'b1);
        write_reg(TIMER, 16'h0001, 1'b0);
        compare("timer enable port", 1, 32'(timer_enable));
        wait_tick(t_last);
        for (int k = 0; k < TICK_PERIODS; k++) begin
            wait_tick(t_now);
            compare($sformatf("tick period %0d", k), 6, 32'(t_now - t_last));
            t_last = t_now;
        end
        @(posedge hwclk);
        #2;
        write_reg(TIMER, 16'h0000, 1'b0);
        compare("timer enable cleared", 0, 32'(timer_enable));

        // external memory, little-endian.
        for (int k = 0; k < 7; k++) begin
            ea = {8'h00, 8'($urandom_range(254, 0))};
            word = 16'($urandom);
            dbl = (k >= 4);
            write_reg(ea, word, dbl);
            compare($sformatf("ext byte0 %0d", k), 32'(word[7:0]), 32'(ext_mem[ea[7:0]]));
            if (dbl) begin
                compare($sformatf("ext byte1 %0d", k), 32'(word[15:8]),
                        32'(ext_mem[ea[7:0] + 8'd1]));
            end
            read_check($sformatf("ext read %0d", k), ea, dbl, dbl ? word : {8'h00, word[7:0]});
            compare($sformatf("ext latency %0d", k), dbl ? 3 : 2, 32'(last_lat));
        end

        afails = u_mmio_subsystem.u_mmio_subsystem_asserts.fail_count;
        $display("checks done: %0d check errors, %0d assertion failures", errors, afails);
        if (errors == 0 && afails == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
